// ==== rtl/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // datapath, register index and byte-lane widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int MBE_W      = XLEN / 8;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;

    // first fetch address out of reset
    localparam word_t RESET_PC = 32'h0000_0060;
    // addi x0, x0, 0 carried by an empty slot
    localparam word_t NOP_INST = 32'h0000_0013;

    // rv32i major opcodes the core understands
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_t;

    // branch funct3 encodings
    typedef enum logic [2:0] {
        br_beq = 3'b000,
        br_bne = 3'b001,
        br_blt = 3'b100,
        br_bge = 3'b101
    } br_op_t;

    // writeback source
    typedef enum logic [1:0] {
        wb_alu,
        wb_imm_u,
        wb_load
    } wb_sel_t;

    typedef struct packed {
        word_t pc;
        word_t inst;
        logic  valid;
    } if_id_t;

    typedef struct packed {
        word_t    pc;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    rs1_val;
        word_t    rs2_val;
        reg_idx_t rd;
        word_t    imm;
        alu_op_t  alu_op;
        logic     use_imm;
        logic     branch;
        br_op_t   br_op;
        logic     load;
        logic     store;
        logic     reg_write;
        wb_sel_t  wb_sel;
        logic     valid;
    } id_ex_t;

    typedef struct packed {
        word_t    alu_res;
        word_t    store_data;
        reg_idx_t rd;
        logic     load;
        logic     store;
        logic     reg_write;
        wb_sel_t  wb_sel;
        logic     valid;
    } ex_mem_t;

    typedef struct packed {
        word_t    result;
        reg_idx_t rd;
        logic     reg_write;
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== rtl/pipe_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipe_reg
    import rv_pkg::*;
#(
    parameter type payload_t = if_id_t
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     hold,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    // an all-zero payload is an empty slot, valid and write flags low
    // bubble wins over hold, so callers gate bubble with the stall
    always_ff @(posedge clk) begin
        if (reset || bubble) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_stage
    import rv_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   stall,
    input  logic   load_use,
    input  logic   redirect,
    input  word_t  redirect_pc,
    output logic   inst_read,
    output word_t  inst_addr,
    input  word_t  inst_rdata,
    output if_id_t if_id
);

    word_t  pc;
    if_id_t if_id_d;

    // freeze first, then taken branch, then load-use hold, else sequential
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (!stall) begin
            if (redirect) begin
                pc <= redirect_pc;
            end else if (!load_use) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // pc is held during a freeze so the request stays stable
    assign inst_read = ~reset;
    assign inst_addr = pc;

    assign if_id_d.pc    = pc;
    assign if_id_d.inst  = inst_rdata;
    assign if_id_d.valid = 1'b1;

    // wrong-path fetch is dropped on a taken branch
    pipe_reg #(.payload_t(if_id_t)) if_id_reg (
        .clk    (clk),
        .reset  (reset),
        .hold   (stall | load_use),
        .bubble (redirect & ~stall),
        .d      (if_id_d),
        .q      (if_id)
    );

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output word_t    rdata1,
    output word_t    rdata2
);

    word_t regs [2**REG_ADDR_W];

    // architectural registers start at zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads zero; same-cycle write goes straight through to the reader
    always_comb begin
        rdata1 = regs[raddr1];
        rdata2 = regs[raddr2];
        if (we && waddr == raddr1) begin
            rdata1 = wdata;
        end
        if (we && waddr == raddr2) begin
            rdata2 = wdata;
        end
        if (raddr1 == '0) begin
            rdata1 = '0;
        end
        if (raddr2 == '0) begin
            rdata2 = '0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_stage
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     stall,
    input  logic     load_use,
    input  logic     redirect,
    input  if_id_t   if_id,
    input  mem_wb_t  wb,
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx,
    output id_ex_t   id_ex
);

    word_t    inst;
    opcode_t  opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t    i_imm;
    word_t    s_imm;
    word_t    b_imm;
    word_t    u_imm;
    word_t    rs1_val;
    word_t    rs2_val;
    alu_op_t  f3_alu;
    logic     f3_ok;
    logic     alt;
    logic     supported;
    logic     uses_rs1;
    logic     uses_rs2;
    id_ex_t   d;
    id_ex_t   id_ex_d;

    // empty slot decodes as a nop so its indices are zero
    assign inst   = if_id.valid ? if_id.inst : NOP_INST;
    assign opcode = opcode_t'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // sign-extended immediates
    assign i_imm = {{20{inst[31]}}, inst[31:20]};
    assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign b_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign u_imm = {inst[31:12], 12'h000};

    // funct7 bit 5 picks sub (reg only) and sra
    assign alt = funct7[5] & (opcode == op_reg || funct3 == 3'b101);

    // funct3 to alu op, shared by reg and imm forms
    always_comb begin
        f3_ok = 1'b1;
        case (funct3)
            3'b000:  f3_alu = alt ? alu_sub : alu_add;
            3'b001:  f3_alu = alu_sll;
            3'b010:  f3_alu = alu_slt;
            3'b100:  f3_alu = alu_xor;
            3'b101:  f3_alu = alt ? alu_sra : alu_srl;
            3'b110:  f3_alu = alu_or;
            3'b111:  f3_alu = alu_and;
            default: begin
                // sltu family is not kept
                f3_alu = alu_add;
                f3_ok  = 1'b0;
            end
        endcase
    end

    // only used sources are reported, so lui never stalls on its upper bits
    assign rs1_idx = uses_rs1 ? inst[19:15] : '0;
    assign rs2_idx = uses_rs2 ? inst[24:20] : '0;

    reg_file regs (
        .clk    (clk),
        .reset  (reset),
        .we     (wb.reg_write),
        .waddr  (wb.rd),
        .wdata  (wb.result),
        .raddr1 (rs1_idx),
        .raddr2 (rs2_idx),
        .rdata1 (rs1_val),
        .rdata2 (rs2_val)
    );

    // control decode
    always_comb begin
        d         = '0;
        supported = 1'b0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        d.alu_op  = alu_add;
        d.wb_sel  = wb_alu;
        case (opcode)
            op_imm: begin
                supported   = f3_ok;
                uses_rs1    = 1'b1;
                d.alu_op    = f3_alu;
                d.imm       = i_imm;
                d.use_imm   = 1'b1;
                d.reg_write = 1'b1;
            end
            op_reg: begin
                supported   = f3_ok;
                uses_rs1    = 1'b1;
                uses_rs2    = 1'b1;
                d.alu_op    = f3_alu;
                d.reg_write = 1'b1;
            end
            op_lui: begin
                supported   = 1'b1;
                d.imm       = u_imm;
                d.reg_write = 1'b1;
                d.wb_sel    = wb_imm_u;
            end
            op_load: begin
                // word loads only
                supported   = (funct3 == 3'b010);
                uses_rs1    = 1'b1;
                d.imm       = i_imm;
                d.use_imm   = 1'b1;
                d.load      = 1'b1;
                d.reg_write = 1'b1;
                d.wb_sel    = wb_load;
            end
            op_store: begin
                supported = (funct3 == 3'b010);
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                d.imm     = s_imm;
                d.use_imm = 1'b1;
                d.store   = 1'b1;
            end
            op_br: begin
                supported = (funct3 == br_beq || funct3 == br_bne ||
                             funct3 == br_blt || funct3 == br_bge);
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                d.imm     = b_imm;
                d.branch  = 1'b1;
                d.br_op   = br_op_t'(funct3);
            end
            default: begin
                supported = 1'b0;
            end
        endcase
        d.pc      = if_id.pc;
        d.rs1     = rs1_idx;
        d.rs2     = rs2_idx;
        d.rs1_val = rs1_val;
        d.rs2_val = rs2_val;
        d.rd      = inst[11:7];
        d.valid   = 1'b1;
        // anything unknown becomes an empty slot
        id_ex_d   = (supported && if_id.valid) ? d : '0;
    end

    // load-use and taken branch both leave a bubble in EX
    pipe_reg #(.payload_t(id_ex_t)) id_ex_reg (
        .clk    (clk),
        .reset  (reset),
        .hold   (stall),
        .bubble ((redirect & ~stall) | load_use),
        .d      (id_ex_d),
        .q      (id_ex)
    );

endmodule

`default_nettype wire

// ==== rtl/hazard_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module hazard_unit
    import rv_pkg::*;
(
    input  id_ex_t   id_ex,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    input  logic     inst_read,
    input  logic     inst_resp,
    input  logic     data_read,
    input  logic     data_write,
    input  logic     data_resp,
    output logic     stall,
    output logic     load_use
);

    logic load_hit;

    // freeze while any raised request still waits for resp
    assign stall = (inst_read & ~inst_resp) |
                   ((data_read | data_write) & ~data_resp);

    // load in EX whose rd feeds the instruction in ID
    assign load_hit = id_ex.valid & id_ex.load & (id_ex.rd != '0) &
                      ((id_ex.rd == rs1_idx) | (id_ex.rd == rs2_idx));

    // a freeze outranks the load-use bubble
    assign load_use = load_hit & ~stall;

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module execute_stage
    import rv_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    stall,
    input  id_ex_t  id_ex,
    input  ex_mem_t mem_fwd,
    input  mem_wb_t wb_fwd,
    output logic    redirect,
    output word_t   redirect_pc,
    output ex_mem_t ex_mem
);

    word_t   op_a;
    word_t   op_b;
    word_t   alu_b;
    word_t   alu_out;
    logic    taken;
    ex_mem_t ex_mem_d;

    // newest producer wins: MEM, then WB, then the register read
    function automatic word_t fwd(input reg_idx_t idx, input word_t reg_val);
        word_t v;
        v = reg_val;
        if (idx != '0 && wb_fwd.reg_write && wb_fwd.rd == idx) begin
            v = wb_fwd.result;
        end
        if (idx != '0 && mem_fwd.reg_write && mem_fwd.rd == idx) begin
            v = mem_fwd.alu_res;
        end
        return v;
    endfunction

    always_comb begin
        op_a  = fwd(id_ex.rs1, id_ex.rs1_val);
        op_b  = fwd(id_ex.rs2, id_ex.rs2_val);
        alu_b = id_ex.use_imm ? id_ex.imm : op_b;
    end

    // alu
    always_comb begin
        case (id_ex.alu_op)
            alu_sub: alu_out = op_a - alu_b;
            alu_and: alu_out = op_a & alu_b;
            alu_or:  alu_out = op_a | alu_b;
            alu_xor: alu_out = op_a ^ alu_b;
            alu_slt: alu_out = {31'd0, $signed(op_a) < $signed(alu_b)};
            alu_sll: alu_out = op_a << alu_b[4:0];
            alu_srl: alu_out = op_a >> alu_b[4:0];
            alu_sra: alu_out = $signed(op_a) >>> alu_b[4:0];
            default: alu_out = op_a + alu_b;
        endcase
    end

    // branch compare, signed for blt and bge
    always_comb begin
        case (id_ex.br_op)
            br_beq:  taken = (op_a == op_b);
            br_bne:  taken = (op_a != op_b);
            br_blt:  taken = ($signed(op_a) < $signed(op_b));
            br_bge:  taken = ($signed(op_a) >= $signed(op_b));
            default: taken = 1'b0;
        endcase
    end

    assign redirect    = id_ex.valid & id_ex.branch & taken;
    assign redirect_pc = id_ex.pc + id_ex.imm;

    // lui result rides in alu_res so MEM forwarding sees it
    assign ex_mem_d.alu_res    = (id_ex.wb_sel == wb_imm_u) ? id_ex.imm : alu_out;
    assign ex_mem_d.store_data = op_b;
    assign ex_mem_d.rd         = id_ex.rd;
    assign ex_mem_d.load       = id_ex.load;
    assign ex_mem_d.store      = id_ex.store;
    assign ex_mem_d.reg_write  = id_ex.reg_write;
    assign ex_mem_d.wb_sel     = id_ex.wb_sel;
    assign ex_mem_d.valid      = id_ex.valid;

    pipe_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
        .clk    (clk),
        .reset  (reset),
        .hold   (stall),
        .bubble (1'b0),
        .d      (ex_mem_d),
        .q      (ex_mem)
    );

endmodule

`default_nettype wire

// ==== rtl/memory_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module memory_stage
    import rv_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             stall,
    input  ex_mem_t          ex_mem,
    output logic             data_read,
    output logic             data_write,
    output word_t            data_addr,
    output word_t            data_wdata,
    output logic [MBE_W-1:0] data_mbe,
    input  logic             data_resp,
    input  word_t            data_rdata,
    output mem_wb_t          mem_wb
);

    logic    data_done;
    word_t   load_q;
    word_t   load_word;
    mem_wb_t mem_wb_d;

    // access finished but a fetch still freezes the pipe
    // drop the request so it is not issued twice
    always_ff @(posedge clk) begin
        if (reset || !stall) begin
            data_done <= 1'b0;
        end else if (data_resp && (data_read || data_write)) begin
            data_done <= 1'b1;
        end
    end

    // keep read data for a load that completes during a freeze
    always_ff @(posedge clk) begin
        if (data_resp) begin
            load_q <= data_rdata;
        end
    end

    assign data_read  = ex_mem.valid & ex_mem.load & ~data_done;
    assign data_write = ex_mem.valid & ex_mem.store & ~data_done;
    assign data_addr  = {ex_mem.alu_res[XLEN-1:2], 2'b00};
    assign data_wdata = ex_mem.store_data;
    // word accesses only
    assign data_mbe   = '1;

    assign load_word = data_done ? load_q : data_rdata;

    assign mem_wb_d.result    = (ex_mem.wb_sel == wb_load) ? load_word : ex_mem.alu_res;
    assign mem_wb_d.rd        = ex_mem.rd;
    assign mem_wb_d.reg_write = ex_mem.valid & ex_mem.reg_write;

    pipe_reg #(.payload_t(mem_wb_t)) mem_wb_reg (
        .clk    (clk),
        .reset  (reset),
        .hold   (stall),
        .bubble (1'b0),
        .d      (mem_wb_d),
        .q      (mem_wb)
    );

endmodule

`default_nettype wire

// ==== rtl/cpu_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_core
    import rv_pkg::*;
(
    input  logic             clk,
    input  logic             reset,

    // instruction port
    output logic             inst_read,
    output word_t            inst_addr,
    input  logic             inst_resp,
    input  word_t            inst_rdata,

    // data port
    output logic             data_read,
    output logic             data_write,
    output word_t            data_addr,
    output word_t            data_wdata,
    output logic [MBE_W-1:0] data_mbe,
    input  logic             data_resp,
    input  word_t            data_rdata
);

    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    mem_wb_t  mem_wb;
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    logic     stall;
    logic     load_use;
    logic     redirect;
    word_t    redirect_pc;

    fetch_stage fetch (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .load_use    (load_use),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .inst_read   (inst_read),
        .inst_addr   (inst_addr),
        .inst_rdata  (inst_rdata),
        .if_id       (if_id)
    );

    // WB result feeds the register file inside decode
    decode_stage decode (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .load_use (load_use),
        .redirect (redirect),
        .if_id    (if_id),
        .wb       (mem_wb),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .id_ex    (id_ex)
    );

    execute_stage execute (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .id_ex       (id_ex),
        .mem_fwd     (ex_mem),
        .wb_fwd      (mem_wb),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .ex_mem      (ex_mem)
    );

    memory_stage memory (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .ex_mem     (ex_mem),
        .data_read  (data_read),
        .data_write (data_write),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_mbe   (data_mbe),
        .data_resp  (data_resp),
        .data_rdata (data_rdata),
        .mem_wb     (mem_wb)
    );

    hazard_unit hazard (
        .id_ex      (id_ex),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .inst_read  (inst_read),
        .inst_resp  (inst_resp),
        .data_read  (data_read),
        .data_write (data_write),
        .data_resp  (data_resp),
        .stall      (stall),
        .load_use   (load_use)
    );

endmodule

`default_nettype wire

// ==== tb/tb_cpu_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_core
    import rv_pkg::*;
();

    // about 50 instructions, two accesses each, up to 4 cycles apiece, plus margin
    localparam int MAX_CYCLES   = 2000;
    localparam int DRAIN_CYCLES = 20;
    localparam int MEM_WORDS    = 64;

    logic             clk        = 1'b0;
    logic             reset      = 1'b1;
    logic             inst_read;
    word_t            inst_addr;
    logic             inst_resp  = 1'b0;
    word_t            inst_rdata = '0;
    logic             data_read;
    logic             data_write;
    word_t            data_addr;
    word_t            data_wdata;
    logic [MBE_W-1:0] data_mbe;
    logic             data_resp  = 1'b0;
    word_t            data_rdata = '0;

    word_t  imem [MEM_WORDS];
    word_t  dmem [MEM_WORDS];
    int     wr_ptr;
    integer seed             = 32'h2a9a32aa;
    int     inst_left        = -1;
    int     data_left        = -1;
    int     cycles           = 0;
    int     since_reset      = 0;
    logic   first_fetch_seen = 1'b0;
    logic   prev_inst_read   = 1'b0;
    word_t  prev_inst_addr   = '0;
    logic   prev_data_read   = 1'b0;
    logic   prev_data_write  = 1'b0;
    word_t  prev_data_addr   = '0;
    word_t  prev_data_wdata  = '0;

    // stores still to come, in program order
    string exp_name [$];
    word_t exp_addr [$];
    word_t exp_data [$];

    cpu_core UUT (
        .clk        (clk),
        .reset      (reset),
        .inst_read  (inst_read),
        .inst_addr  (inst_addr),
        .inst_resp  (inst_resp),
        .inst_rdata (inst_rdata),
        .data_read  (data_read),
        .data_write (data_write),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_mbe   (data_mbe),
        .data_resp  (data_resp),
        .data_rdata (data_rdata)
    );

    always #4 clk = ~clk;

    task automatic report_error(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string what, input word_t expected, input word_t actual);
        $display("MISMATCH %s expected %h actual %h", what, expected, actual);
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    // rv32i encoders
    function automatic word_t enc_r(input logic [2:0] f3, input reg_idx_t rd,
                                    input reg_idx_t rs1, input reg_idx_t rs2, input logic alt);
        return {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t enc_imm(input logic [2:0] f3, input reg_idx_t rd,
                                      input reg_idx_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic word_t enc_lw(input reg_idx_t rd, input reg_idx_t rs1,
                                     input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic word_t enc_sw(input reg_idx_t rs2, input reg_idx_t rs1,
                                     input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // branch offset in bytes, bit 0 dropped
    function automatic word_t enc_br(input logic [2:0] f3, input reg_idx_t rs1,
                                     input reg_idx_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t enc_u(input reg_idx_t rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    task automatic emit(input word_t inst);
        imem[wr_ptr] = inst;
        wr_ptr = wr_ptr + 1;
    endtask

    task automatic expect_store(input string name, input word_t addr, input word_t data);
        exp_name.push_back(name);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic load_program;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = 32'h0000_0013;
            // data words carry their own byte address
            dmem[i] = 32'hd000_0000 | (i << 2);
        end
        wr_ptr = RESET_PC >> 2;
        // x1 lui, x2 one behind, x4 and x5 reach back two and three
        emit(enc_u(5'd1, 20'h12345));
        emit(enc_imm(3'b000, 5'd2, 5'd1, 12'h678));
        emit(enc_imm(3'b000, 5'd3, 5'd0, 12'd5));
        emit(enc_r(3'b000, 5'd4, 5'd2, 5'd1, 1'b1));
        emit(enc_r(3'b001, 5'd5, 5'd4, 5'd3, 1'b0));
        emit(enc_sw(5'd2, 5'd0, 12'd0));
        emit(enc_sw(5'd5, 5'd0, 12'd4));
        emit(enc_r(3'b110, 5'd6, 5'd5, 5'd4, 1'b0));
        // store data straight from the previous result
        emit(enc_sw(5'd6, 5'd0, 12'd8));
        // sra, srl, slt, xor, and on a negative value
        emit(enc_imm(3'b000, 5'd7, 5'd0, 12'hff0));
        emit(enc_r(3'b101, 5'd8, 5'd7, 5'd3, 1'b1));
        emit(enc_r(3'b101, 5'd9, 5'd7, 5'd3, 1'b0));
        emit(enc_r(3'b010, 5'd10, 5'd7, 5'd3, 1'b0));
        emit(enc_r(3'b100, 5'd11, 5'd9, 5'd6, 1'b0));
        emit(enc_r(3'b111, 5'd12, 5'd11, 5'd2, 1'b0));
        emit(enc_sw(5'd8, 5'd0, 12'd12));
        emit(enc_sw(5'd9, 5'd0, 12'd16));
        emit(enc_sw(5'd10, 5'd0, 12'd20));
        emit(enc_sw(5'd12, 5'd0, 12'd24));
        // load then immediate use, first as rs1 then as rs2
        emit(enc_lw(5'd13, 5'd0, 12'd0));
        emit(enc_imm(3'b000, 5'd14, 5'd13, 12'd1));
        emit(enc_sw(5'd14, 5'd0, 12'd28));
        emit(enc_lw(5'd15, 5'd0, 12'h080));
        emit(enc_r(3'b000, 5'd16, 5'd3, 5'd15, 1'b0));
        emit(enc_sw(5'd16, 5'd0, 12'd32));
        // taken beq over two stores, bne falls through
        emit(enc_br(3'b000, 5'd3, 5'd3, 13'd12));
        emit(enc_sw(5'd7, 5'd0, 12'd36));
        emit(enc_sw(5'd7, 5'd0, 12'd40));
        emit(enc_br(3'b001, 5'd3, 5'd3, 13'd8));
        emit(enc_sw(5'd4, 5'd0, 12'd44));
        // taken blt over one store, bge falls through
        emit(enc_br(3'b100, 5'd7, 5'd3, 13'd8));
        emit(enc_sw(5'd7, 5'd0, 12'd48));
        emit(enc_br(3'b101, 5'd7, 5'd3, 13'd8));
        emit(enc_sw(5'd1, 5'd0, 12'd52));
        // park on a branch to itself
        emit(enc_br(3'b000, 5'd0, 5'd0, 13'd0));
    endtask

    task automatic load_expected;
        expect_store("fwd addi after lui", 32'h00, 32'h1234_5678);
        expect_store("fwd sll", 32'h04, 32'h0000_cf00);
        expect_store("fwd or into store", 32'h08, 32'h0000_cf78);
        expect_store("sra", 32'h0c, 32'hffff_ffff);
        expect_store("srl", 32'h10, 32'h07ff_ffff);
        expect_store("slt", 32'h14, 32'h0000_0001);
        expect_store("xor and", 32'h18, 32'h0234_1000);
        expect_store("load use rs1", 32'h1c, 32'h1234_5679);
        expect_store("load use rs2", 32'h20, 32'hd000_0085);
        expect_store("bne fall through", 32'h2c, 32'h0000_0678);
        expect_store("bge fall through", 32'h34, 32'h1234_5000);
    endtask

    // a completing store must match the head of the list
    task automatic check_store;
        if (exp_addr.size() == 0) begin
            report_error($sformatf("store to %h with data %h when none was expected",
                                   data_addr, data_wdata));
        end else begin
            assert (data_addr == exp_addr[0])
                else report_mismatch({exp_name[0], " address"}, exp_addr[0], data_addr);
            assert (data_wdata == exp_data[0])
                else report_mismatch({exp_name[0], " data"}, exp_data[0], data_wdata);
            void'(exp_name.pop_front());
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
        end
    endtask

    // memory models, each request answered after 0 to 3 cycles
    always @(negedge clk) begin
        if (reset || !inst_read) begin
            inst_left = -1;
            inst_resp <= 1'b0;
        end else begin
            if (inst_left < 0) begin
                inst_left = $unsigned($random(seed)) % 4;
            end
            if (inst_left == 0) begin
                inst_resp  <= 1'b1;
                inst_rdata <= imem[inst_addr[7:2]];
            end else begin
                inst_resp <= 1'b0;
            end
            inst_left = inst_left - 1;
        end
        if (reset || !(data_read || data_write)) begin
            data_left = -1;
            data_resp <= 1'b0;
        end else begin
            if (data_left < 0) begin
                data_left = $unsigned($random(seed)) % 4;
            end
            if (data_left == 0) begin
                data_resp <= 1'b1;
                if (data_read) begin
                    data_rdata <= dmem[data_addr[7:2]];
                end
                if (data_write) begin
                    check_store();
                    dmem[data_addr[7:2]] = data_wdata;
                end
            end else begin
                data_resp <= 1'b0;
            end
            data_left = data_left - 1;
        end
    end

    // port checks, sampled mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            since_reset = 0;
            assert (!inst_read) else report_error("fetch request raised during reset");
        end else begin
            since_reset = since_reset + 1;
        end
        // quiet through reset and the first cycle after
        if (reset || since_reset <= 1) begin
            assert (!data_read && !data_write)
                else report_error("data request raised during or right after reset");
        end
        if (!reset && inst_read && !first_fetch_seen) begin
            assert (inst_addr == RESET_PC) else report_mismatch("first fetch", RESET_PC, inst_addr);
            first_fetch_seen = 1'b1;
        end
        // request and its payload held until resp
        if (prev_inst_read && !inst_resp) begin
            assert (inst_read) else report_error("fetch request dropped before its resp");
            assert (inst_addr == prev_inst_addr)
                else report_mismatch("held inst_addr", prev_inst_addr, inst_addr);
        end
        if ((prev_data_read || prev_data_write) && !data_resp) begin
            assert (data_read == prev_data_read && data_write == prev_data_write)
                else report_error("data request changed before its resp");
            assert (data_addr == prev_data_addr)
                else report_mismatch("held data_addr", prev_data_addr, data_addr);
            assert (data_wdata == prev_data_wdata)
                else report_mismatch("held data_wdata", prev_data_wdata, data_wdata);
        end
        if (data_write) begin
            assert (data_mbe == '1)
                else report_mismatch("data_mbe", 32'h0000_000f, word_t'(data_mbe));
        end
        assert (data_addr[1:0] == 2'b00)
            else report_mismatch("data_addr alignment", {data_addr[31:2], 2'b00}, data_addr);
        prev_inst_read  = inst_read;
        prev_inst_addr  = inst_addr;
        prev_data_read  = data_read;
        prev_data_write = data_write;
        prev_data_addr  = data_addr;
        prev_data_wdata = data_wdata;
    end

    initial begin
        load_program();
        load_expected();
        repeat (2) @(negedge clk);
        reset <= 1'b0;
        while (exp_addr.size() != 0 && cycles < MAX_CYCLES) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        if (exp_addr.size() != 0) begin
            report_error($sformatf("cycle limit of %0d reached with %0d stores outstanding",
                                   MAX_CYCLES, exp_addr.size()));
        end else begin
            // a stray store after the last expected one still gets caught
            repeat (DRAIN_CYCLES) @(negedge clk);
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/rv_pkg.sv
rtl/pipe_reg.sv
rtl/fetch_stage.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/cpu_core.sv
tb/tb_cpu_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cpu_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_cpu_core -f list.f -o tb_cpu_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_cpu_core > "$LOG" 2>&1
sim_status=$?

if ! cat "$LOG"; then
    echo "cannot read $LOG"
    exit 1
fi

if grep -q "Checks failed" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

exit 0
